// File: logic/pingpong_pkg.sv
//==========================================================================
// Shared sizes, sample and status types and the swap FSM states of the
// ping-pong sample buffer. Modules refer to it by scoped names.
//==========================================================================
`default_nettype none

package pingpong_pkg;

    //======================================================================
    // Sizes
    //======================================================================
    localparam int DATA_W  = 16;               // Sample width in bits
    localparam int DEPTH   = 16;               // Samples per bank
    localparam int ADDR_W  = $clog2(DEPTH);    // Bank address bits
    localparam int COUNT_W = ADDR_W + 1;       // Extra bit so a count can hold DEPTH

    //======================================================================
    // Scalar types
    //======================================================================
    // One signed audio/ADC style sample
    typedef logic signed [DATA_W-1:0] sample_t;

    typedef logic [ADDR_W-1:0]  addr_t;        // Address inside one bank
    typedef logic [COUNT_W-1:0] count_t;       // Fill level or read position

    //======================================================================
    // Grouped signals
    //======================================================================
    // One write into a bank, sent as a single word
    typedef struct packed {
        logic    en;                           // Write strobe
        addr_t   addr;                         // Target location
        sample_t data;                         // Sample to store
    } bank_wr_t;

    // Status word seen from outside
    typedef struct packed {
        count_t write_count;                   // Samples in the write bank
        count_t read_count;                    // Samples taken from the read bank
    } status_t;

    //======================================================================
    // Swap FSM
    //======================================================================
    typedef enum logic [1:0] {
        WRITING,                               // First fill, nothing to read yet
        SWAP_PENDING,                          // Write bank full, swap next edge
        READING                                // Reader owns the filled bank
    } swap_state_t;

endpackage

`default_nettype wire

// File: logic/sample_ram.sv
//==========================================================================
// One bank of the buffer. Clocked write from a bank write word,
// combinational read so the reader sees data with no latency.
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module sample_ram (
    input  logic                  clk_i,      // System clock
    input  pingpong_pkg::bank_wr_t wr_i,       // Write strobe, address, sample
    input  pingpong_pkg::addr_t   rd_addr_i,  // Read location
    output pingpong_pkg::sample_t rd_data_o   // Sample at rd_addr_i
);

    // Storage, no reset on contents
    pingpong_pkg::sample_t mem_q [pingpong_pkg::DEPTH];

    //======================================================================
    // Write port
    //======================================================================
    always_ff @(posedge clk_i) begin
        if (wr_i.en) begin
            mem_q[wr_i.addr] <= wr_i.data;    // Store on strobe only
        end
    end

    //======================================================================
    // Read port
    //======================================================================
    // Asynchronous read, maps to distributed RAM
    assign rd_data_o = mem_q[rd_addr_i];

endmodule

`default_nettype wire

// File: logic/swap_ctrl.sv
//==========================================================================
// Write side of the ping-pong buffer: write handshake, fill count, bank
// select and the swap FSM that hands a full bank to the read side.
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module swap_ctrl (
    input  logic                     clk_i,          // System clock
    input  logic                     rst_ni,         // Sync reset, active low
    input  pingpong_pkg::sample_t    write_data_i,   // Incoming sample
    input  logic                     write_valid_i,  // Writer has a sample
    output logic                     write_ready_o,  // Room in write bank
    output pingpong_pkg::bank_wr_t   bank0_wr_o,     // Write word to bank 0
    output pingpong_pkg::bank_wr_t   bank1_wr_o,     // Write word to bank 1
    output logic                     swap_o,         // One cycle, bank handed over
    output logic                     read_bank_o,    // Bank owned by reader
    output logic                     reading_o,      // FSM in READING
    output pingpong_pkg::count_t     write_count_o   // Fill level of write bank
);

    //======================================================================
    // State and registers
    //======================================================================
    pingpong_pkg::swap_state_t state_q, state_d;

    pingpong_pkg::addr_t   write_addr_q;   // Next free location
    pingpong_pkg::count_t  write_count_q;  // Samples in write bank
    logic                  write_bank_q;   // 0 = bank 0 is written
    logic                  read_bank_q;
    logic                  ready_q;
    logic                  swap_q;
    logic                  reading_q;

    // Registered bank write, strobes reset and payload not
    logic                  wr_en0_q;
    logic                  wr_en1_q;
    pingpong_pkg::addr_t   wr_addr_q;
    pingpong_pkg::sample_t wr_data_q;

    logic                  write_accept;   // Valid and ready this cycle
    logic                  full;

    assign write_accept = write_valid_i && ready_q;
    assign full         = (write_count_q == pingpong_pkg::count_t'(pingpong_pkg::DEPTH));

    //======================================================================
    // Swap FSM, next state
    //======================================================================
    always_comb begin
        state_d = state_q;                 // Hold by default
        case (state_q)
            pingpong_pkg::WRITING: begin
                if (full) state_d = pingpong_pkg::SWAP_PENDING;
            end
            pingpong_pkg::SWAP_PENDING: begin
                state_d = pingpong_pkg::READING;   // Always one cycle
            end
            pingpong_pkg::READING: begin
                // Other bank full again
                if (full) state_d = pingpong_pkg::SWAP_PENDING;
            end
            default: state_d = pingpong_pkg::WRITING;
        endcase
    end

    //======================================================================
    // Control registers
    //======================================================================
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q       <= pingpong_pkg::WRITING;
            write_addr_q  <= '0;
            write_count_q <= '0;
            write_bank_q  <= 1'b0;         // Bank 0 filled first
            read_bank_q   <= 1'b1;
            ready_q       <= 1'b1;
            swap_q        <= 1'b0;
            reading_q     <= 1'b0;
            wr_en0_q      <= 1'b0;
            wr_en1_q      <= 1'b0;
        end else begin
            state_q   <= state_d;
            reading_q <= (state_d == pingpong_pkg::READING);
            swap_q    <= (state_q == pingpong_pkg::SWAP_PENDING);  // Pulse at swap edge

            // Steer an accepted write to the selected bank only
            wr_en0_q <= write_accept && !write_bank_q;
            wr_en1_q <= write_accept && write_bank_q;

            if (state_q == pingpong_pkg::SWAP_PENDING) begin
                read_bank_q   <= write_bank_q;     // Filled bank to reader
                write_bank_q  <= ~write_bank_q;
                write_addr_q  <= '0;
                write_count_q <= '0;
                ready_q       <= 1'b1;             // Empty bank takes writes again
            end else if (write_accept) begin
                write_addr_q  <= write_addr_q + pingpong_pkg::addr_t'(1);
                write_count_q <= write_count_q + pingpong_pkg::count_t'(1);
                // Drop ready on the edge that takes the last sample
                ready_q       <= (write_count_q + pingpong_pkg::count_t'(1))
                                 < pingpong_pkg::count_t'(pingpong_pkg::DEPTH);
            end
        end
    end

    // Payload of the delayed bank write
    always_ff @(posedge clk_i) begin
        wr_addr_q <= write_addr_q;
        wr_data_q <= write_data_i;
    end

    //======================================================================
    // Outputs
    //======================================================================
    assign bank0_wr_o = pingpong_pkg::bank_wr_t'{en: wr_en0_q, addr: wr_addr_q, data: wr_data_q};
    assign bank1_wr_o = pingpong_pkg::bank_wr_t'{en: wr_en1_q, addr: wr_addr_q, data: wr_data_q};

    assign write_ready_o = ready_q;
    assign swap_o        = swap_q;
    assign read_bank_o   = read_bank_q;
    assign reading_o     = reading_q;
    assign write_count_o = write_count_q;

endmodule

`default_nettype wire

// File: logic/read_sequencer.sv
//==========================================================================
// Read side of the ping-pong buffer. Walks the bank handed over by the
// swap FSM through a valid/ready stream, zero latency from the bank.
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module read_sequencer (
    input  logic                  clk_i,         // System clock
    input  logic                  rst_ni,        // Sync reset, active low
    input  logic                  swap_i,        // New bank ready pulse
    input  logic                  read_bank_i,   // Bank owned by reader
    input  logic                  reading_i,     // Swap FSM in READING
    input  logic                  read_ready_i,  // Reader takes a sample
    input  pingpong_pkg::sample_t bank0_data_i,  // Read data of bank 0
    input  pingpong_pkg::sample_t bank1_data_i,  // Read data of bank 1
    output pingpong_pkg::addr_t   rd_addr_o,     // Shared read address
    output pingpong_pkg::sample_t read_data_o,   // Sample at current position
    output logic                  read_valid_o,  // Sample available
    output pingpong_pkg::count_t  read_count_o   // Samples taken so far
);

    //======================================================================
    // Registers
    //======================================================================
    pingpong_pkg::addr_t  rd_addr_q;
    pingpong_pkg::count_t read_count_q;
    logic                 valid_q;

    // Position as seen this cycle
    pingpong_pkg::addr_t  addr_cur;
    pingpong_pkg::count_t pos_cur;
    logic                 valid_cur;
    logic                 last_read;
    logic                 read_accept;

    //======================================================================
    // Current position
    //======================================================================
    // Swap pulse restarts at 0 in the same cycle it is shown
    assign addr_cur  = swap_i ? '0 : rd_addr_q;
    assign pos_cur   = swap_i ? '0 : read_count_q;
    assign valid_cur = swap_i || valid_q;

    // Nothing offered while the FSM swaps banks
    assign read_valid_o = valid_cur && reading_i;
    assign read_accept  = read_valid_o && read_ready_i;

    assign last_read = (pos_cur == pingpong_pkg::count_t'(pingpong_pkg::DEPTH - 1));

    //======================================================================
    // Position update
    //======================================================================
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            rd_addr_q    <= '0;
            read_count_q <= '0;
            valid_q      <= 1'b0;          // Nothing to read before first swap
        end else if (read_accept) begin
            rd_addr_q    <= addr_cur + pingpong_pkg::addr_t'(1);
            read_count_q <= pos_cur + pingpong_pkg::count_t'(1);
            valid_q      <= !last_read;    // Bank drained, wait for next swap
        end else begin
            // Latch a restart, otherwise hold
            rd_addr_q    <= addr_cur;
            read_count_q <= pos_cur;
            valid_q      <= valid_cur;
        end
    end

    //======================================================================
    // Outputs
    //======================================================================
    assign rd_addr_o    = addr_cur;        // Same address to both banks
    assign read_count_o = pos_cur;

    // Pick the reader's bank, zero outside READING
    always_comb begin
        if (!reading_i) begin
            read_data_o = '0;
        end else if (read_bank_i) begin
            read_data_o = bank1_data_i;
        end else begin
            read_data_o = bank0_data_i;
        end
    end

endmodule

`default_nettype wire

// File: logic/pingpong_buffer.sv
//==========================================================================
// Top level of the two-bank ping-pong sample buffer. A writer fills one
// bank while a reader drains the other, buffer_ready_o marks each swap.
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module pingpong_buffer (
    input  logic                  clk_i,           // System clock
    input  logic                  rst_ni,          // Sync reset, active low
    // Write stream
    input  pingpong_pkg::sample_t write_data_i,
    input  logic                  write_valid_i,
    output logic                  write_ready_o,
    // Read stream
    output pingpong_pkg::sample_t read_data_o,
    output logic                  read_valid_o,
    input  logic                  read_ready_i,
    // Status
    output logic                  buffer_ready_o,  // One cycle per filled bank
    output pingpong_pkg::status_t status_o
);

    //======================================================================
    // Internal wires
    //======================================================================
    pingpong_pkg::bank_wr_t bank0_wr;
    pingpong_pkg::bank_wr_t bank1_wr;
    pingpong_pkg::addr_t    rd_addr;         // Shared by both banks
    pingpong_pkg::sample_t  bank0_data;
    pingpong_pkg::sample_t  bank1_data;
    pingpong_pkg::count_t   write_count;
    pingpong_pkg::count_t   read_count;
    logic                   read_bank;
    logic                   reading;

    //======================================================================
    // Write side and swap FSM
    //======================================================================
    swap_ctrl u_swap_ctrl (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .write_data_i  (write_data_i),
        .write_valid_i (write_valid_i),
        .write_ready_o (write_ready_o),
        .bank0_wr_o    (bank0_wr),
        .bank1_wr_o    (bank1_wr),
        .swap_o        (buffer_ready_o),     // Swap pulse is the ready pulse
        .read_bank_o   (read_bank),
        .reading_o     (reading),
        .write_count_o (write_count)
    );

    //======================================================================
    // Read side
    //======================================================================
    read_sequencer u_read_sequencer (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .swap_i       (buffer_ready_o),
        .read_bank_i  (read_bank),
        .reading_i    (reading),
        .read_ready_i (read_ready_i),
        .bank0_data_i (bank0_data),
        .bank1_data_i (bank1_data),
        .rd_addr_o    (rd_addr),
        .read_data_o  (read_data_o),
        .read_valid_o (read_valid_o),
        .read_count_o (read_count)
    );

    //======================================================================
    // Banks
    //======================================================================
    sample_ram u_bank0 (
        .clk_i     (clk_i),
        .wr_i      (bank0_wr),
        .rd_addr_i (rd_addr),
        .rd_data_o (bank0_data)
    );

    sample_ram u_bank1 (
        .clk_i     (clk_i),
        .wr_i      (bank1_wr),
        .rd_addr_i (rd_addr),
        .rd_data_o (bank1_data)
    );

    // Status word, fill level above read position
    assign status_o = pingpong_pkg::status_t'{write_count: write_count, read_count: read_count};

endmodule

`default_nettype wire

// File: verification/pingpong_buffer_properties.sv
//==========================================================================
// Concurrent checks on the ping-pong buffer ports. Attached to the top
// level with bind.
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module pingpong_buffer_properties (
    input logic                  clk_i,
    input logic                  rst_ni,
    input logic                  buffer_ready_o,
    input logic                  read_valid_o,
    input logic                  write_ready_o,
    input pingpong_pkg::status_t status_o
);

    // Swap pulse opens a fresh read at position 0
    a_pulse_starts_read: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        buffer_ready_o |-> (read_valid_o && status_o.read_count == '0)
    ) else $error("buffer_ready_o seen without read_valid_o at read position 0");

    // Writer only held off by a full bank
    a_ready_low_when_full: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        !write_ready_o |->
            (status_o.write_count == pingpong_pkg::count_t'(pingpong_pkg::DEPTH))
    ) else $error("write_ready_o low while the write bank is not full");

    // One cycle only
    a_pulse_single_cycle: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        buffer_ready_o |=> !buffer_ready_o
    ) else $error("buffer_ready_o high on two cycles in a row");

endmodule

bind pingpong_buffer pingpong_buffer_properties u_pingpong_buffer_properties (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .buffer_ready_o (buffer_ready_o),
    .read_valid_o   (read_valid_o),
    .write_ready_o  (write_ready_o),
    .status_o       (status_o)
);

`default_nettype wire

// File: verification/pingpong_buffer_tb.sv
//==========================================================================
// Testbench for the ping-pong sample buffer. Streams random samples in,
// drains the banks and compares every read against recorded writes.
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module pingpong_buffer_tb;

    localparam int DEPTH   = pingpong_pkg::DEPTH;
    localparam int TIMEOUT = 500;              // Cycles per wait loop
    localparam int STALL   = 0;                // Reader modes
    localparam int RANDOM  = 1;
    localparam int FULL    = 2;

    logic                  clk_i;
    logic                  rst_ni;
    pingpong_pkg::sample_t write_data_i;
    logic                  write_valid_i;
    logic                  write_ready_o;
    pingpong_pkg::sample_t read_data_o;
    logic                  read_valid_o;
    logic                  read_ready_i;
    logic                  buffer_ready_o;
    pingpong_pkg::status_t status_o;

    integer                seed;
    string                 test_name;
    int                    read_mode;
    pingpong_pkg::sample_t written_q [$];      // Every accepted write, in order
    int                    pulses_seen;        // Also index of next buffer
    int                    cur_buf;            // Buffer owned by reader
    int                    reads_in_buf;       // Reads taken from cur_buf
    int                    cycle;
    int                    fill_cycle;         // Edge of last DEPTH-th write
    logic                  prev_pulse;

    pingpong_buffer u_pingpong_buffer (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .write_data_i   (write_data_i),
        .write_valid_i  (write_valid_i),
        .write_ready_o  (write_ready_o),
        .read_data_o    (read_data_o),
        .read_valid_o   (read_valid_o),
        .read_ready_i   (read_ready_i),
        .buffer_ready_o (buffer_ready_o),
        .status_o       (status_o)
    );

    always #20 clk_i = ~clk_i;                 // 40 ns period

    //======================================================================
    // Reference model and compare tasks
    //======================================================================
    // Buffer b holds writes b*DEPTH up to b*DEPTH+DEPTH-1
    function automatic pingpong_pkg::sample_t expected_sample(input int bidx, input int pos);
        return written_q[bidx * DEPTH + pos];
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_sample(input string name, input pingpong_pkg::sample_t exp,
                                input pingpong_pkg::sample_t act);
        if (exp !== act)
            stop_on_error($sformatf("** Error [%s] %s: expected %0d, actual %0d",
                                    test_name, name, exp, act));
    endtask

    task automatic check_count(input string name, input pingpong_pkg::count_t exp,
                               input pingpong_pkg::count_t act);
        if (exp !== act)
            stop_on_error($sformatf("** Error [%s] %s: expected %0d, actual %0d",
                                    test_name, name, exp, act));
    endtask

    task automatic check_status(input string name, input pingpong_pkg::status_t exp,
                                input pingpong_pkg::status_t act);
        if (exp !== act)
            stop_on_error($sformatf("** Error [%s] %s: expected w=%0d r=%0d, actual w=%0d r=%0d",
                                    test_name, name, exp.write_count, exp.read_count,
                                    act.write_count, act.read_count));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act)
            stop_on_error($sformatf("** Error [%s] %s: expected %b, actual %b",
                                    test_name, name, exp, act));
    endtask

    //======================================================================
    // Compare process, samples pre-edge values at every rising edge
    //======================================================================
    always @(posedge clk_i) begin : compare
        logic pulse;
        int   bidx;
        int   pos;
        int   fill;
        if (rst_ni) begin
            pulse = buffer_ready_o;
            bidx  = pulse ? pulses_seen : cur_buf;   // Pulse hands over next buffer
            pos   = pulse ? 0 : reads_in_buf;
            // Writes since the last swap, each pulse marks a cleared bank
            fill  = written_q.size() - DEPTH * (pulses_seen + (pulse ? 1 : 0));
            if (pulse) begin
                check_bit("buffer ready two cycles in a row", 1'b0, prev_pulse);
                check_count("edges from last write to pulse", 2,
                            pingpong_pkg::count_t'(cycle - 1 - fill_cycle));
                check_bit("one pulse per DEPTH writes", 1'b1,
                          written_q.size() == (pulses_seen + 1) * DEPTH);
                check_bit("read valid at pulse", 1'b1, read_valid_o);
                check_status("status at pulse", '0, status_o);
            end
            if (cycle == fill_cycle + 1) check_bit("write ready after fill", 1'b0, write_ready_o);
            if (cycle == fill_cycle + 2) begin            // Swap pending cycle
                check_bit("read valid during swap", 1'b0, read_valid_o);
                check_sample("read data during swap", '0, read_data_o);
            end
            check_count("write count", pingpong_pkg::count_t'(fill), status_o.write_count);
            check_bit("write ready vs fill count", fill < DEPTH, write_ready_o);
            if (pulses_seen == 0 && !pulse) check_sample("read data before swap", '0, read_data_o);
            if (pos == DEPTH) check_bit("read valid after drain", 1'b0, read_valid_o);
            if (read_valid_o && read_ready_i) begin
                check_count("read count", pingpong_pkg::count_t'(pos), status_o.read_count);
                check_sample($sformatf("read data buffer %0d pos %0d", bidx, pos),
                             expected_sample(bidx, pos), read_data_o);
                pos++;
            end
            if (write_valid_i && write_ready_o) begin
                written_q.push_back(write_data_i);
                if (written_q.size() % DEPTH == 0) fill_cycle <= cycle;
            end
            if (pulse) begin
                pulses_seen <= pulses_seen + 1;
                cur_buf     <= bidx;
            end
            reads_in_buf <= pos;
            prev_pulse   <= pulse;
            cycle        <= cycle + 1;
        end
    end

    // Reader draws never share an edge with the writer's draws
    always @(posedge clk_i) begin
        if (read_mode == FULL) read_ready_i <= 1'b1;
        else if (read_mode == RANDOM) read_ready_i <= (($random(seed) & 3) != 0);
        else read_ready_i <= 1'b0;
    end

    //======================================================================
    // Stimulus helpers
    //======================================================================
    task automatic write_samples(input int count, input int max_gap);
        int i;
        int gap;
        int t;
        for (i = 0; i < count; i++) begin
            gap = ($random(seed) & 32'h7fff_ffff) % (max_gap + 1);
            if (gap > 0) begin
                write_valid_i <= 1'b0;
                repeat (gap) @(posedge clk_i);     // Idle gap on the writer
            end
            write_data_i  <= pingpong_pkg::sample_t'($random(seed));
            write_valid_i <= 1'b1;
            t = 0;
            do begin
                @(posedge clk_i);
                t++;
                if (t > TIMEOUT) stop_on_error("Timeout: write sample was never accepted");
            end while (!write_ready_o);
        end
        write_valid_i <= 1'b0;
    endtask

    task automatic wait_pulses(input int target);
        int t;
        t = 0;
        while (pulses_seen < target) begin
            @(posedge clk_i);
            t++;
            if (t > TIMEOUT) stop_on_error("Timeout: buffer ready pulse did not arrive");
        end
    endtask

    task automatic wait_reads(input int target);
        int t;
        t = 0;
        while (reads_in_buf < target) begin
            @(posedge clk_i);
            t++;
            if (t > TIMEOUT) stop_on_error("Timeout: reader did not reach the read count");
        end
    endtask

    //======================================================================
    // Test sequence
    //======================================================================
    initial begin
        seed          = 70;
        test_name     = "reset";
        clk_i         = 1'b0;
        rst_ni        = 1'b0;
        write_data_i  = '0;
        write_valid_i = 1'b0;
        read_ready_i  = 1'b0;
        read_mode     = STALL;
        pulses_seen   = 0;
        cur_buf       = 0;
        reads_in_buf  = DEPTH;                 // Nothing readable before first swap
        cycle         = 0;
        fill_cycle    = -100;
        prev_pulse    = 1'b0;
        repeat (5) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(posedge clk_i);
        check_bit("write ready", 1'b1, write_ready_o);
        check_bit("read valid", 1'b0, read_valid_o);
        check_bit("buffer ready", 1'b0, buffer_ready_o);
        check_sample("read data", '0, read_data_o);
        check_status("status", '0, status_o);

        test_name = "fill_and_swap";
        write_samples(DEPTH, 3);
        wait_pulses(1);

        test_name = "read_out";
        read_mode <= RANDOM;
        wait_reads(DEPTH);
        read_mode <= STALL;
        repeat (8) @(posedge clk_i);           // Valid must stay low here
        check_bit("read valid after drain", 1'b0, read_valid_o);

        test_name = "streaming";
        read_mode <= FULL;
        write_samples(3 * DEPTH, 3);
        wait_pulses(4);
        wait_reads(DEPTH);

        test_name = "abandoned_read";
        read_mode <= STALL;
        write_samples(DEPTH, 2);
        wait_pulses(5);
        read_mode <= RANDOM;
        wait_reads(5);
        read_mode <= STALL;                    // Leave buffer 4 half read
        @(posedge clk_i);                      // Reader stops drawing first
        write_samples(DEPTH, 2);
        wait_pulses(6);
        check_count("read count after restart", '0, status_o.read_count);
        read_mode <= FULL;
        wait_reads(DEPTH);

        check_count("buffer ready pulses", 6, pingpong_pkg::count_t'(pulses_seen));
        $display("Testbench passed");
        $finish;
    end

    // Overall guard in simulated time
    initial begin
        #400000;
        stop_on_error("Timeout: simulation ran past its time limit");
    end

endmodule

`default_nettype wire

// File: build.f
logic/pingpong_pkg.sv
logic/sample_ram.sv
logic/swap_ctrl.sv
logic/read_sequencer.sv
logic/pingpong_buffer.sv
verification/pingpong_buffer_properties.sv
verification/pingpong_buffer_tb.sv
